//--- ps2_bus_pkg.sv
`default_nettype none

package ps2_bus_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Frame geometry and bus timing
	////////////////////////////////////////////////////////////////////////////

	// Start, eight data bits, odd parity and stop
	localparam int FRAME_BITS = 11;

	// Default timing, overridden from the top level
	localparam int DEF_CLK_PER_US       = 50;
	localparam int DEF_FILTER_LEN       = 8;
	localparam int DEF_FRAME_TIMEOUT_US = 2000;
	localparam int DEF_IDLE_US          = 100;

	////////////////////////////////////////////////////////////////////////////
	// Line and frame types
	////////////////////////////////////////////////////////////////////////////

	// Filtered pin state of one port
	typedef struct packed {
		logic clk_level;
		logic data_level;
		logic clk_fall;
	} ps2_line_t;

	// One finished frame with its check results
	typedef struct packed {
		logic [7:0] code;
		logic       parity_err;
		logic       framing_err;
		logic       timeout;
	} ps2_frame_t;

endpackage

`default_nettype wire

//--- ps2_event_pkg.sv
`default_nettype none

package ps2_event_pkg;

	// Which connector a frame came from
	typedef enum logic {
		PORT_KBD = 1'b0,
		PORT_AUX = 1'b1
	} ps2_port_e;

	// Tagged event seen at the top level
	typedef struct packed {
		ps2_port_e               source;
		ps2_bus_pkg::ps2_frame_t frame;
		logic                    overrun;
	} ps2_event_t;

endpackage

`default_nettype wire

//--- ps2_tick_gen.sv
`default_nettype none

module ps2_tick_gen #(
	parameter int CLK_PER_US = 50
) (
	input  logic clk_main_loop,
	input  logic rst,
	output logic us_tick
);

	localparam int CNT_W = $clog2(CLK_PER_US + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLK_PER_US - 1);

	logic [CNT_W-1:0] cnt;

	// Wrapping count, one strobe per microsecond
	always_ff @(posedge clk_main_loop) begin
		if (rst) begin
			cnt     <= '0;
			us_tick <= 1'b0;
		end else if (cnt == CNT_LAST) begin
			cnt     <= '0;
			us_tick <= 1'b1;
		end else begin
			cnt     <= cnt + 1'b1;
			us_tick <= 1'b0;
		end
	end

	// Strobe is a single cycle wide
	a_tick_single: assert property (@(posedge clk_main_loop) disable iff (rst)
		us_tick |=> !us_tick)
		else $error("us_tick high in two consecutive cycles");

endmodule

`default_nettype wire

//--- ps2_line_sync.sv
`default_nettype none

module ps2_line_sync #(
	parameter int FILTER_LEN = 8
) (
	input  logic                   clk_main_loop,
	input  logic                   rst,
	input  logic                   pin_clk,
	input  logic                   pin_data,
	output ps2_bus_pkg::ps2_line_t line
);

	localparam int PIN_CLK  = 0;
	localparam int PIN_DATA = 1;
	localparam int CNT_W    = $clog2(FILTER_LEN + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(FILTER_LEN - 1);

	logic [1:0]       pins;
	logic [1:0]       sync_a;
	logic [1:0]       sync_b;
	logic [1:0]       level;
	logic [1:0]       settle;
	logic [CNT_W-1:0] cnt [2];
	logic             clk_fall;

	assign pins = {pin_data, pin_clk};

	// Sample differs from the level for FILTER_LEN cycles in a row
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			settle[i] = (sync_b[i] != level[i]) && (cnt[i] == CNT_LAST);
		end
	end

	// Idle bus is high on both lines
	always_ff @(posedge clk_main_loop) begin
		if (rst) begin
			sync_a   <= 2'b11;
			sync_b   <= 2'b11;
			level    <= 2'b11;
			clk_fall <= 1'b0;
			for (int i = 0; i < 2; i++) begin
				cnt[i] <= '0;
			end
		end else begin
			sync_a   <= pins;
			sync_b   <= sync_a;
			// Old level high and about to flip means a falling edge
			clk_fall <= settle[PIN_CLK] & level[PIN_CLK];
			for (int i = 0; i < 2; i++) begin
				if (sync_b[i] == level[i] || settle[i]) begin
					cnt[i] <= '0;
				end else begin
					cnt[i] <= cnt[i] + 1'b1;
				end
				if (settle[i]) begin
					level[i] <= sync_b[i];
				end
			end
		end
	end

	assign line.clk_level  = level[PIN_CLK];
	assign line.data_level = level[PIN_DATA];
	assign line.clk_fall   = clk_fall;

	// Edge strobe lines up with the new low level
	a_fall_on_edge: assert property (@(posedge clk_main_loop) disable iff (rst)
		line.clk_fall |-> !line.clk_level && $past(line.clk_level))
		else $error("clk_fall without a filtered falling edge");

endmodule

`default_nettype wire

//--- ps2_frame_reader.sv
`default_nettype none

module ps2_frame_reader #(
	parameter int FRAME_TIMEOUT_US = 2000,
	parameter int IDLE_US          = 100
) (
	input  logic                    clk_main_loop,
	input  logic                    rst,
	input  logic                    enable,
	input  logic                    us_tick,
	input  ps2_bus_pkg::ps2_line_t  line,
	output logic                    reading,
	output logic                    frame_valid,
	output ps2_bus_pkg::ps2_frame_t frame
);

	import ps2_bus_pkg::*;

	localparam int BIT_W  = $clog2(FRAME_BITS + 1);
	localparam int TO_W   = $clog2(FRAME_TIMEOUT_US + 1);
	localparam int IDLE_W = $clog2(IDLE_US + 1);

	localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(FRAME_BITS - 1);
	localparam logic [TO_W-1:0]   TO_LAST   = TO_W'(FRAME_TIMEOUT_US - 1);
	localparam logic [IDLE_W-1:0] IDLE_LAST = IDLE_W'(IDLE_US - 1);

	typedef enum logic [1:0] {
		ST_IDLE     = 2'd0,
		ST_SHIFT    = 2'd1,
		ST_END_WAIT = 2'd2,
		ST_DONE     = 2'd3
	} state_e;

	state_e                state;
	logic [FRAME_BITS-1:0] shreg;
	logic [BIT_W-1:0]      bit_cnt;
	logic [TO_W-1:0]       to_cnt;
	logic [IDLE_W-1:0]     idle_cnt;
	logic                  timed_out;
	logic                  bus_idle;
	logic                  idle_done;
	ps2_frame_t            decoded;

	assign bus_idle  = line.clk_level && line.data_level;
	assign idle_done = bus_idle && us_tick && (idle_cnt == IDLE_LAST);

	////////////////////////////////////////////////////////////////////////////
	// Frame FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_main_loop) begin
		if (rst) begin
			state     <= ST_IDLE;
			bit_cnt   <= '0;
			to_cnt    <= '0;
			idle_cnt  <= '0;
			timed_out <= 1'b0;
		end else if (!enable) begin
			// Drop any partial frame
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (line.clk_fall) begin
						state     <= ST_SHIFT;
						bit_cnt   <= BIT_W'(1);
						to_cnt    <= '0;
						timed_out <= 1'b0;
					end
				end
				ST_SHIFT: begin
					if (us_tick) begin
						to_cnt <= to_cnt + 1'b1;
					end
					if (line.clk_fall) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == BIT_LAST) begin
							state    <= ST_END_WAIT;
							idle_cnt <= '0;
						end
					end else if (us_tick && to_cnt == TO_LAST) begin
						// Stalled frame, finish through the idle wait
						state     <= ST_END_WAIT;
						idle_cnt  <= '0;
						timed_out <= 1'b1;
					end
				end
				ST_END_WAIT: begin
					if (!bus_idle) begin
						idle_cnt <= '0;
					end else if (idle_done) begin
						state <= ST_DONE;
					end else if (us_tick) begin
						idle_cnt <= idle_cnt + 1'b1;
					end
				end
				ST_DONE: begin
					state <= ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Data path
	////////////////////////////////////////////////////////////////////////////

	// LSB first, so new bits enter at the top
	always_ff @(posedge clk_main_loop) begin
		if (enable && line.clk_fall) begin
			if (state == ST_IDLE) begin
				shreg <= {line.data_level, {(FRAME_BITS - 1){1'b0}}};
			end else if (state == ST_SHIFT) begin
				shreg <= {line.data_level, shreg[FRAME_BITS-1:1]};
			end
		end
	end

	// Bit 0 start, bits 8 to 1 data, bit 9 parity, bit 10 stop
	// Error flags only apply to complete frames
	always_comb begin
		decoded.code        = shreg[8:1];
		decoded.parity_err  = !timed_out && !(^shreg[9:1]);
		decoded.framing_err = !timed_out && (shreg[0] || !shreg[FRAME_BITS-1]);
		decoded.timeout     = timed_out;
	end

	always_ff @(posedge clk_main_loop) begin
		if (state == ST_END_WAIT && idle_done) begin
			frame <= decoded;
		end
	end

	assign reading     = (state == ST_SHIFT) || (state == ST_END_WAIT);
	assign frame_valid = (state == ST_DONE);

	a_bit_cnt_range: assert property (@(posedge clk_main_loop) disable iff (rst)
		bit_cnt <= BIT_W'(FRAME_BITS))
		else $error("frame reader bit counter beyond frame length");

	a_valid_single: assert property (@(posedge clk_main_loop) disable iff (rst)
		frame_valid |=> !frame_valid)
		else $error("frame_valid high in two consecutive cycles");

endmodule

`default_nettype wire

//--- ps2_event_merge.sv
`default_nettype none

module ps2_event_merge (
	input  logic                      clk_main_loop,
	input  logic                      rst,
	input  logic                      kbd_valid,
	input  ps2_bus_pkg::ps2_frame_t   kbd_frame,
	input  logic                      aux_valid,
	input  ps2_bus_pkg::ps2_frame_t   aux_frame,
	output logic                      event_valid,
	output ps2_event_pkg::ps2_event_t event_data
);

	import ps2_bus_pkg::*;
	import ps2_event_pkg::*;

	localparam int NUM_PORTS = 2;

	logic [NUM_PORTS-1:0] in_valid;
	ps2_frame_t           in_frame [NUM_PORTS];
	ps2_frame_t           slot     [NUM_PORTS];
	logic [NUM_PORTS-1:0] full;
	logic [NUM_PORTS-1:0] ovr;
	logic [NUM_PORTS-1:0] issue;
	ps2_port_e            sel;

	assign in_valid[PORT_KBD] = kbd_valid;
	assign in_valid[PORT_AUX] = aux_valid;
	assign in_frame[PORT_KBD] = kbd_frame;
	assign in_frame[PORT_AUX] = aux_frame;

	////////////////////////////////////////////////////////////////////////////
	// Arbitration
	////////////////////////////////////////////////////////////////////////////

	// Keyboard slot wins when both are full
	always_comb begin
		sel        = full[PORT_KBD] ? PORT_KBD : PORT_AUX;
		issue      = '0;
		issue[sel] = |full;
	end

	assign event_valid        = |full;
	assign event_data.source  = sel;
	assign event_data.frame   = slot[sel];
	assign event_data.overrun = ovr[sel];

	////////////////////////////////////////////////////////////////////////////
	// One slot per port
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_main_loop) begin
		if (rst) begin
			full <= '0;
			ovr  <= '0;
		end else begin
			for (int i = 0; i < NUM_PORTS; i++) begin
				if (in_valid[i]) begin
					full[i] <= 1'b1;
					// Unsent frame is overwritten and flagged until reported
					ovr[i]  <= !issue[i] && full[i];
				end else if (issue[i]) begin
					full[i] <= 1'b0;
					ovr[i]  <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk_main_loop) begin
		for (int i = 0; i < NUM_PORTS; i++) begin
			if (in_valid[i]) begin
				slot[i] <= in_frame[i];
			end
		end
	end

	// A slot only empties through an issued event
	for (genvar g = 0; g < NUM_PORTS; g++) begin : g_slot_chk
		a_slot_kept: assert property (@(posedge clk_main_loop) disable iff (rst)
			full[g] && !issue[g] |=> full[g])
			else $error("merge slot %0d emptied without an event", g);
	end

endmodule

`default_nettype wire

//--- ps2_dual_port.sv
`default_nettype none

module ps2_dual_port #(
	parameter int CLK_PER_US       = ps2_bus_pkg::DEF_CLK_PER_US,
	parameter int FILTER_LEN       = ps2_bus_pkg::DEF_FILTER_LEN,
	parameter int FRAME_TIMEOUT_US = ps2_bus_pkg::DEF_FRAME_TIMEOUT_US,
	parameter int IDLE_US          = ps2_bus_pkg::DEF_IDLE_US
) (
	input  logic                      clk_main_loop,
	input  logic                      rst,
	input  logic                      kbd_enable,
	input  logic                      aux_enable,
	input  logic                      ps2_kbd_clk,
	input  logic                      ps2_kbd_data,
	input  logic                      ps2_aux_clk,
	input  logic                      ps2_aux_data,
	output logic                      kbd_reading,
	output logic                      aux_reading,
	output logic                      event_valid,
	output ps2_event_pkg::ps2_event_t event_data
);

	import ps2_bus_pkg::*;

	logic       us_tick;
	ps2_line_t  kbd_line;
	ps2_line_t  aux_line;
	logic       kbd_valid;
	logic       aux_valid;
	ps2_frame_t kbd_frame;
	ps2_frame_t aux_frame;

	// Shared microsecond time base
	ps2_tick_gen #(
		.CLK_PER_US(CLK_PER_US)
	) tick_gen0 (
		.clk_main_loop(clk_main_loop),
		.rst          (rst),
		.us_tick      (us_tick)
	);

	////////////////////////////////////////////////////////////////////////////
	// Keyboard port
	////////////////////////////////////////////////////////////////////////////

	ps2_line_sync #(
		.FILTER_LEN(FILTER_LEN)
	) kbd_sync0 (
		.clk_main_loop(clk_main_loop),
		.rst          (rst),
		.pin_clk      (ps2_kbd_clk),
		.pin_data     (ps2_kbd_data),
		.line         (kbd_line)
	);

	ps2_frame_reader #(
		.FRAME_TIMEOUT_US(FRAME_TIMEOUT_US),
		.IDLE_US         (IDLE_US)
	) kbd_reader0 (
		.clk_main_loop(clk_main_loop),
		.rst          (rst),
		.enable       (kbd_enable),
		.us_tick      (us_tick),
		.line         (kbd_line),
		.reading      (kbd_reading),
		.frame_valid  (kbd_valid),
		.frame        (kbd_frame)
	);

	////////////////////////////////////////////////////////////////////////////
	// Aux port
	////////////////////////////////////////////////////////////////////////////

	ps2_line_sync #(
		.FILTER_LEN(FILTER_LEN)
	) aux_sync0 (
		.clk_main_loop(clk_main_loop),
		.rst          (rst),
		.pin_clk      (ps2_aux_clk),
		.pin_data     (ps2_aux_data),
		.line         (aux_line)
	);

	ps2_frame_reader #(
		.FRAME_TIMEOUT_US(FRAME_TIMEOUT_US),
		.IDLE_US         (IDLE_US)
	) aux_reader0 (
		.clk_main_loop(clk_main_loop),
		.rst          (rst),
		.enable       (aux_enable),
		.us_tick      (us_tick),
		.line         (aux_line),
		.reading      (aux_reading),
		.frame_valid  (aux_valid),
		.frame        (aux_frame)
	);

	// Both ports into one tagged stream
	ps2_event_merge merge0 (
		.clk_main_loop(clk_main_loop),
		.rst          (rst),
		.kbd_valid    (kbd_valid),
		.kbd_frame    (kbd_frame),
		.aux_valid    (aux_valid),
		.aux_frame    (aux_frame),
		.event_valid  (event_valid),
		.event_data   (event_data)
	);

endmodule

`default_nettype wire

//--- tb_ps2_dual_port.sv
`default_nettype none

module tb_ps2_dual_port;

	import ps2_bus_pkg::*;
	import ps2_event_pkg::*;

	// Reduced timing keeps the run short
	localparam int CLK_PER_US       = 2;
	localparam int FILTER_LEN       = 3;
	localparam int FRAME_TIMEOUT_US = 2000;
	localparam int IDLE_US          = 100;

	// 20 us half bit period of the emulated device
	localparam int HALF_BIT_CYC = 20 * CLK_PER_US;

	logic       clk_main_loop = 1'b0;
	logic       rst;
	logic       kbd_enable;
	logic       aux_enable;
	logic       ps2_kbd_clk;
	logic       ps2_kbd_data;
	logic       ps2_aux_clk;
	logic       ps2_aux_data;
	logic       kbd_reading;
	logic       aux_reading;
	logic       event_valid;
	ps2_event_t event_data;

	ps2_event_t  expected_q [$];
	int          cycle_cnt = 0;
	int          evt_cycle [2];
	logic        aux_off_check = 1'b0;
	int unsigned seed_val;

	ps2_dual_port #(
		.CLK_PER_US      (CLK_PER_US),
		.FILTER_LEN      (FILTER_LEN),
		.FRAME_TIMEOUT_US(FRAME_TIMEOUT_US),
		.IDLE_US         (IDLE_US)
	) dut0 (
		.clk_main_loop(clk_main_loop),
		.rst          (rst),
		.kbd_enable   (kbd_enable),
		.aux_enable   (aux_enable),
		.ps2_kbd_clk  (ps2_kbd_clk),
		.ps2_kbd_data (ps2_kbd_data),
		.ps2_aux_clk  (ps2_aux_clk),
		.ps2_aux_data (ps2_aux_data),
		.kbd_reading  (kbd_reading),
		.aux_reading  (aux_reading),
		.event_valid  (event_valid),
		.event_data   (event_data)
	);

	always #10 clk_main_loop = ~clk_main_loop;

	////////////////////////////////////////////////////////////////////////////
	// Failure reporting and compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_event(input ps2_event_t exp, input ps2_event_t got);
		if (got !== exp) begin
			report_failure($sformatf("[ERROR] event_data expected %h got %h", exp, got));
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			report_failure($sformatf("[ERROR] %s expected %h got %h", name, exp, got));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Frame building and expected results
	////////////////////////////////////////////////////////////////////////////

	// Bit 0 goes on the wire first
	function automatic logic [10:0] frame_bits(input logic [7:0] data, input bit inv_par,
		input logic stop);
		logic parity;
		parity = ~(^data) ^ inv_par;
		return {stop, parity, data, 1'b0};
	endfunction

	function automatic ps2_event_t expected_event(input ps2_port_e src, input logic [7:0] data,
		input bit inv_par, input logic stop, input int nbits);
		logic [10:0] bits;
		logic [10:0] sh;
		ps2_event_t  ev;
		bits = frame_bits(data, inv_par, stop);
		sh   = '0;
		// Each received bit enters at the top
		for (int i = 0; i < nbits; i++) begin
			sh = {bits[i], sh[10:1]};
		end
		ev.source            = src;
		ev.overrun           = 1'b0;
		ev.frame.code        = sh[8:1];
		ev.frame.timeout     = (nbits < FRAME_BITS);
		// Checks only count on complete frames
		ev.frame.parity_err  = !ev.frame.timeout && inv_par;
		ev.frame.framing_err = !ev.frame.timeout && !stop;
		return ev;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Device emulation
	////////////////////////////////////////////////////////////////////////////

	task automatic send_kbd(input logic [7:0] data, input bit inv_par, input logic stop,
		input int nbits);
		logic [10:0] bits;
		bits = frame_bits(data, inv_par, stop);
		for (int i = 0; i < nbits; i++) begin
			ps2_kbd_data = bits[i];
			repeat (HALF_BIT_CYC) @(negedge clk_main_loop);
			ps2_kbd_clk = 1'b0;
			repeat (HALF_BIT_CYC) @(negedge clk_main_loop);
			ps2_kbd_clk = 1'b1;
		end
		@(negedge clk_main_loop);
		ps2_kbd_data = 1'b1;
	endtask

	task automatic send_aux(input logic [7:0] data, input bit inv_par, input logic stop,
		input int nbits);
		logic [10:0] bits;
		bits = frame_bits(data, inv_par, stop);
		for (int i = 0; i < nbits; i++) begin
			ps2_aux_data = bits[i];
			repeat (HALF_BIT_CYC) @(negedge clk_main_loop);
			ps2_aux_clk = 1'b0;
			repeat (HALF_BIT_CYC) @(negedge clk_main_loop);
			ps2_aux_clk = 1'b1;
		end
		@(negedge clk_main_loop);
		ps2_aux_data = 1'b1;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Waits
	////////////////////////////////////////////////////////////////////////////

	task automatic wait_for_events(input int max_us, input string what);
		int waited;
		waited = 0;
		while (expected_q.size() != 0 && waited < max_us * CLK_PER_US) begin
			@(negedge clk_main_loop);
			waited++;
		end
		if (expected_q.size() != 0) begin
			report_failure($sformatf("timed out waiting for %s", what));
		end
	endtask

	// Quiet window, the monitor flags anything unexpected
	task automatic watch_quiet(input int span_us);
		int waited;
		waited = 0;
		while (waited < span_us * CLK_PER_US) begin
			@(negedge clk_main_loop);
			waited++;
		end
	endtask

	// Outputs come from registers, sample away from the rising edge
	always @(negedge clk_main_loop) begin
		cycle_cnt = cycle_cnt + 1;
		if (!rst && event_valid) begin
			if (expected_q.size() == 0) begin
				report_failure($sformatf("unexpected event %h from the DUT", event_data));
			end else begin
				check_event(expected_q.pop_front(), event_data);
				evt_cycle[int'(event_data.source)] = cycle_cnt;
			end
		end
	end

	always @(negedge clk_main_loop) begin
		if (aux_off_check) begin
			check_level("aux_reading", 1'b0, aux_reading);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin : main_seq
		logic [7:0] data;
		rst          = 1'b1;
		kbd_enable   = 1'b1;
		aux_enable   = 1'b1;
		ps2_kbd_clk  = 1'b1;
		ps2_kbd_data = 1'b1;
		ps2_aux_clk  = 1'b1;
		ps2_aux_data = 1'b1;
		seed_val     = $urandom(32'h8765_ff43);
		repeat (4) @(negedge clk_main_loop);
		rst = 1'b0;
		@(negedge clk_main_loop);
		check_level("event_valid", 1'b0, event_valid);
		check_level("kbd_reading", 1'b0, kbd_reading);
		check_level("aux_reading", 1'b0, aux_reading);

		// Random bytes on each port
		for (int n = 0; n < 3; n++) begin
			data = 8'($urandom());
			expected_q.push_back(expected_event(PORT_KBD, data, 1'b0, 1'b1, FRAME_BITS));
			send_kbd(data, 1'b0, 1'b1, FRAME_BITS);
			check_level("kbd_reading", 1'b1, kbd_reading);
			wait_for_events(IDLE_US + 50, "keyboard event");
			check_level("kbd_reading", 1'b0, kbd_reading);
		end
		for (int n = 0; n < 3; n++) begin
			data = 8'($urandom());
			expected_q.push_back(expected_event(PORT_AUX, data, 1'b0, 1'b1, FRAME_BITS));
			send_aux(data, 1'b0, 1'b1, FRAME_BITS);
			check_level("aux_reading", 1'b1, aux_reading);
			wait_for_events(IDLE_US + 50, "aux event");
			check_level("aux_reading", 1'b0, aux_reading);
		end

		// Bad parity, then bad stop bit
		data = 8'($urandom());
		expected_q.push_back(expected_event(PORT_KBD, data, 1'b1, 1'b1, FRAME_BITS));
		send_kbd(data, 1'b1, 1'b1, FRAME_BITS);
		wait_for_events(IDLE_US + 50, "parity error event");
		data = 8'($urandom());
		expected_q.push_back(expected_event(PORT_AUX, data, 1'b0, 1'b0, FRAME_BITS));
		send_aux(data, 1'b0, 1'b0, FRAME_BITS);
		wait_for_events(IDLE_US + 50, "framing error event");

		// Stalled frame after five bits
		data = 8'($urandom());
		expected_q.push_back(expected_event(PORT_KBD, data, 1'b0, 1'b1, 5));
		send_kbd(data, 1'b0, 1'b1, 5);
		check_level("kbd_reading", 1'b1, kbd_reading);
		wait_for_events(FRAME_TIMEOUT_US + IDLE_US + 100, "timeout event");
		check_level("kbd_reading", 1'b0, kbd_reading);

		// Both ports finish together
		data = 8'($urandom());
		expected_q.push_back(expected_event(PORT_KBD, data, 1'b0, 1'b1, FRAME_BITS));
		expected_q.push_back(expected_event(PORT_AUX, data, 1'b0, 1'b1, FRAME_BITS));
		fork
			send_kbd(data, 1'b0, 1'b1, FRAME_BITS);
			send_aux(data, 1'b0, 1'b1, FRAME_BITS);
		join
		wait_for_events(IDLE_US + 50, "simultaneous events");
		if (evt_cycle[int'(PORT_AUX)] - evt_cycle[int'(PORT_KBD)] != 1) begin
			report_failure("aux event did not follow the keyboard event by one cycle");
		end

		// Aux port disabled while the keyboard keeps running
		aux_enable    = 1'b0;
		@(negedge clk_main_loop);
		aux_off_check = 1'b1;
		data = 8'($urandom());
		expected_q.push_back(expected_event(PORT_KBD, data, 1'b0, 1'b1, FRAME_BITS));
		fork
			send_kbd(data, 1'b0, 1'b1, FRAME_BITS);
			send_aux(8'($urandom()), 1'b0, 1'b1, FRAME_BITS);
		join
		wait_for_events(IDLE_US + 50, "keyboard event with aux disabled");
		watch_quiet(IDLE_US + 50);
		aux_off_check = 1'b0;
		aux_enable    = 1'b1;
		@(negedge clk_main_loop);

		if (expected_q.size() != 0) begin
			report_failure("expected events still pending at the end of the run");
		end else begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- ps2_dual_port.f
ps2_bus_pkg.sv
ps2_event_pkg.sv
ps2_tick_gen.sv
ps2_line_sync.sv
ps2_frame_reader.sv
ps2_event_merge.sv
ps2_dual_port.sv
tb_ps2_dual_port.sv
